// File: bench/link_master_assert.sv
`timescale 1ns/1ps
`default_nettype none

module link_master_assert (
  input logic              clk_wr,
  input logic              arst_n,
  input logic              tx_online_delay,
  input logic              rx_online_delay,
  input phy_pkg::phy_bus_t tx_phy,
  input link_pkg::flit_t   rx_flit
);

  logic all_marked;

  // Marker and strobe on every lane
  always_comb begin
    all_marked = 1'b1;
    for (int l = 0; l < phy_pkg::lanes; l++) begin
      all_marked = all_marked & tx_phy[l].mrk & tx_phy[l].stb;
    end
  end

  tx_quiet: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !tx_online_delay |=> (tx_phy == '0))
    else $error("tx_phy active while transmit side offline");

  rx_quiet: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !rx_online_delay |=> !rx_flit.valid)
    else $error("rx_flit valid while receive side offline");

  // Persistent user bits once transmit is up
  lanes_marked: assert property (@(posedge clk_wr) disable iff (!arst_n)
    tx_online_delay |=> all_marked)
    else $error("lane marker or strobe missing while online");

endmodule

`default_nettype wire

// File: bench/link_master_vectors.txt
// tx_online rx_online marker_clear_mask dstrm_flit expected_ustrm_flit
// one step per clock, all hex, mask bit n clears the marker of lane n
1 1 0 1deadbeefcafe12345677 0
1 1 0 0 0
1 1 0 0 0
1 1 0 0a5a5a5a5a5a5a5a5a5a5 0a5a5a5a5a5a5a5a5a5a5
1 1 0 13c3c3c3c3c3c3c3c3c3f 13c3c3c3c3c3c3c3c3c3f
1 1 0 0 0
1 1 4 0fedcba98765432100f01 0
1 1 0 100000000000000000001 100000000000000000001
1 1 9 0ffffffffffffffffffff 0
1 1 0 0123456789abcdef01235 0123456789abcdef01235
1 1 0 0 0
1 1 0 0 0
1 0 0 0000000000000000000ab 0
0 0 0 0 0
0 0 0 0 0

// File: bench/tb_link_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_link_master;

  localparam int n_steps         = 15;
  localparam int fields          = 5;
  localparam int n_iter          = n_steps + 6;
  localparam int watchdog_cycles = n_steps * 10 + 200;
  localparam logic [phy_pkg::delay_w-1:0] delay_x_val = 16'd3;
  localparam logic [phy_pkg::delay_w-1:0] delay_y_val = 16'd2;
  // First payload bit of lane 3 above the flit
  localparam int spare_lo = link_pkg::flit_w - (phy_pkg::lanes - 1) * phy_pkg::payload_w;

  logic                        clk_wr;
  logic                        arst_n;
  logic                        tx_online;
  logic                        rx_online;
  logic [phy_pkg::delay_w-1:0] delay_x;
  logic [phy_pkg::delay_w-1:0] delay_y;
  link_pkg::flit_t             dstrm_flit;
  link_pkg::flit_t             ustrm_flit;
  phy_pkg::phy_bus_t           tx_phy;
  phy_pkg::phy_bus_t           rx_phy;
  phy_pkg::phy_bus_t           corrupt;
  link_pkg::dbg_t              debug_status;

  logic [83:0]       vec_mem [0:fields*n_steps-1];
  // Reference state after each clock edge of the run
  logic              tx_flag [0:n_iter];
  logic              rx_flag [0:n_iter];
  link_pkg::flit_t   exp_tx  [0:n_iter];
  phy_pkg::phy_bus_t exp_phy [0:n_iter];
  integer            seed;
  int                errors;
  int                checks;

  always #50 clk_wr = ~clk_wr;

  // Lane loopback with marker corruption
  assign rx_phy = tx_phy ^ corrupt;

  link_master_top DUT (
    .clk_wr       (clk_wr),
    .arst_n       (arst_n),
    .tx_online    (tx_online),
    .rx_online    (rx_online),
    .delay_x      (delay_x),
    .delay_y      (delay_y),
    .dstrm_flit   (dstrm_flit),
    .ustrm_flit   (ustrm_flit),
    .tx_phy       (tx_phy),
    .rx_phy       (rx_phy),
    .debug_status (debug_status)
  );

  bind link_lane_concat link_master_assert link_master_assert_i (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_phy          (tx_phy),
    .rx_flit         (rx_flit)
  );

  //////////////////////////////////////////////////////////////////////
  // Vector access and reference model

  function automatic logic [83:0] vec_field(input int step, input int idx);
    if (step < 0 || step >= n_steps) begin
      return '0;
    end
    return vec_mem[step*fields + idx];
  endfunction

  // Lane l carries flit bits from l*22, spare bits zero
  function automatic phy_pkg::phy_bus_t lane_map(input link_pkg::flit_t f);
    logic [phy_pkg::lanes*phy_pkg::payload_w-1:0] flat;
    phy_pkg::phy_bus_t                            bus;
    flat = {{(phy_pkg::lanes*phy_pkg::payload_w-link_pkg::flit_w){1'b0}}, f};
    for (int l = 0; l < phy_pkg::lanes; l++) begin
      bus[l].stb     = 1'b1;
      bus[l].mrk     = 1'b1;
      bus[l].payload = flat[l*phy_pkg::payload_w +: phy_pkg::payload_w];
    end
    return bus;
  endfunction

  // Step k is sampled at edge k+1, flag up after delay_x sampled highs
  task automatic build_model();
    int          run;
    int          rx_run;
    logic [83:0] raw;
    run        = 0;
    rx_run     = 0;
    tx_flag[0] = 1'b0;
    rx_flag[0] = 1'b0;
    exp_tx[0]  = '0;
    exp_phy[0] = '0;
    for (int i = 1; i <= n_iter; i++) begin
      run        = (vec_field(i - 1, 0) != '0) ? run + 1 : 0;
      // Receive side also needs the delayed transmit flag
      rx_run     = (vec_field(i - 1, 1) != '0 && tx_flag[i-1]) ? rx_run + 1 : 0;
      raw        = vec_field(i - 1, 3);
      tx_flag[i] = run >= int'(delay_x_val);
      rx_flag[i] = rx_run >= int'(delay_y_val);
      exp_tx[i]  = tx_flag[i-1] ? raw[link_pkg::flit_w-1:0] : '0;
      exp_phy[i] = tx_flag[i-1] ? lane_map(exp_tx[i-1]) : '0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_flit(input link_pkg::flit_t got, input link_pkg::flit_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0d ns %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_phy(input phy_pkg::phy_bus_t got, input phy_pkg::phy_bus_t exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0d ns %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_debug(input link_pkg::dbg_t got, input link_pkg::dbg_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0d ns %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    link_pkg::dbg_t exp_dbg;
    logic [83:0]    raw;
    logic [31:0]    noise;
    errors     = 0;
    checks     = 0;
    seed       = 80;
    clk_wr     = 1'b0;
    arst_n     = 1'b0;
    tx_online  = 1'b0;
    rx_online  = 1'b0;
    delay_x    = delay_x_val;
    delay_y    = delay_y_val;
    dstrm_flit = '0;
    corrupt    = '0;
    exp_dbg    = '0;
    $readmemh("bench/link_master_vectors.txt", vec_mem);
    build_model();

    repeat (8) @(posedge clk_wr);
    #5;
    arst_n = 1'b1;
    check_phy(tx_phy, '0, "tx_phy after reset");
    check_flit(ustrm_flit, '0, "ustrm_flit after reset");
    check_debug(debug_status, '0, "debug_status after reset");

    // Last pass only checks, its stimulus is idle
    for (int i = 0; i <= n_iter; i++) begin
      @(posedge clk_wr);
      #5;
      check_phy(tx_phy, exp_phy[i], "tx_phy");
      // Round trip through the loopback is 4 cycles
      if (i >= 4) begin
        raw = vec_field(i - 4, 4);
        check_flit(ustrm_flit, raw[link_pkg::flit_w-1:0], "ustrm_flit");
      end
      // Counters move at the edge after each event
      if (i >= 1 && exp_tx[i-1].valid) begin
        exp_dbg.tx_flit_cnt = exp_dbg.tx_flit_cnt + 1'b1;
      end
      raw = vec_field(i - 4, 4);
      if (raw[0]) begin
        exp_dbg.rx_flit_cnt = exp_dbg.rx_flit_cnt + 1'b1;
      end
      if (i >= 4 && rx_flag[i-2] && vec_field(i - 4, 2) != '0) begin
        exp_dbg.marker_err_cnt = exp_dbg.marker_err_cnt + 1'b1;
      end
      exp_dbg.tx_online_delay = tx_flag[i];
      exp_dbg.rx_online_delay = rx_flag[i];
      check_debug(debug_status, exp_dbg, "debug_status");
      raw        = vec_field(i, 0);
      tx_online  = raw[0];
      raw        = vec_field(i, 1);
      rx_online  = raw[0];
      raw        = vec_field(i, 3);
      dstrm_flit = raw[link_pkg::flit_w-1:0];
      // tx_phy now holds the word of step i-2
      raw     = vec_field(i - 2, 2);
      corrupt = '0;
      for (int l = 0; l < phy_pkg::lanes; l++) begin
        corrupt[l].mrk = raw[l];
      end
      noise = $random(seed);
      corrupt[phy_pkg::lanes-1].payload[phy_pkg::payload_w-1:spare_lo] =
        noise[phy_pkg::payload_w-spare_lo-1:0];
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clk_wr);
    $display("Watchdog expired before the vector run completed");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
logic/link_pkg.sv
logic/phy_pkg.sv
logic/link_auto_sync.sv
logic/link_user_if.sv
logic/link_lane_concat.sv
logic/link_master_top.sv
bench/link_master_assert.sv
bench/tb_link_master.sv

// File: logic/link_auto_sync.sv
`timescale 1ns/1ps
`default_nettype none

module link_auto_sync (
  input  logic                        clk_wr,
  input  logic                        arst_n,
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic [phy_pkg::delay_w-1:0] delay_x,
  input  logic [phy_pkg::delay_w-1:0] delay_y,
  output logic                        tx_online_delay,
  output logic                        rx_online_delay,
  output logic                        tx_mrk,
  output logic                        tx_stb
);

  // Channel 0 is transmit, channel 1 is receive
  logic [1:0]                  go;
  logic [phy_pkg::delay_w-1:0] limit [2];
  logic [phy_pkg::delay_w-1:0] cnt   [2];
  logic [1:0]                  online_q;

  // Receive side waits for the delayed transmit flag
  assign go[0]    = tx_online;
  assign go[1]    = rx_online & online_q[0];
  assign limit[0] = delay_x;
  assign limit[1] = delay_y;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      cnt[0]   <= '0;
      cnt[1]   <= '0;
      online_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!go[i]) begin
          cnt[i]      <= '0;
          online_q[i] <= 1'b0;
        end else if (!online_q[i]) begin
          // Counter stops once the flag is up
          cnt[i]      <= cnt[i] + 1'b1;
          online_q[i] <= (cnt[i] + 1'b1) >= limit[i];
        end
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  // Persistent marker and strobe
  assign tx_mrk = online_q[0];
  assign tx_stb = online_q[0];

endmodule

`default_nettype wire

// File: logic/link_lane_concat.sv
`timescale 1ns/1ps
`default_nettype none

module link_lane_concat (
  input  logic              clk_wr,
  input  logic              arst_n,
  input  link_pkg::flit_t   tx_flit,
  output link_pkg::flit_t   rx_flit,
  output phy_pkg::phy_bus_t tx_phy,
  input  phy_pkg::phy_bus_t rx_phy,
  input  logic              tx_online_delay,
  input  logic              rx_online_delay,
  input  logic              tx_mrk,
  input  logic              tx_stb,
  output logic              marker_err
);

  // Flat payload across all lanes, flit in the low bits
  logic [phy_pkg::lanes*phy_pkg::payload_w-1:0] tx_bits;
  logic [phy_pkg::lanes*phy_pkg::payload_w-1:0] rx_bits;
  logic [phy_pkg::lane_w-1:0]                   tx_word [phy_pkg::lanes];
  phy_pkg::phy_bus_t                            tx_next;
  logic                                         mrk_all;

  ////////////////////////////////////////////////////////////////////
  // Transmit, flit to lanes

  always_comb begin
    tx_bits                            = '0;
    tx_bits[link_pkg::flit_w-1:0]      = tx_flit;
    for (int i = 0; i < phy_pkg::lanes; i++) begin
      tx_word[i]                       = '0;
      tx_word[i][phy_pkg::strobe_bit]  = tx_stb;
      tx_word[i][phy_pkg::marker_bit]  = tx_mrk;
      tx_word[i][phy_pkg::payload_w-1:0] =
        tx_bits[i*phy_pkg::payload_w +: phy_pkg::payload_w];
      tx_next[i]                       = phy_pkg::lane_t'(tx_word[i]);
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else if (tx_online_delay) begin
      tx_phy <= tx_next;
    end else begin
      tx_phy <= '0;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Receive, lanes to flit

  // Every lane must mark the word boundary
  always_comb begin
    rx_bits = '0;
    mrk_all = 1'b1;
    for (int i = 0; i < phy_pkg::lanes; i++) begin
      rx_bits[i*phy_pkg::payload_w +: phy_pkg::payload_w] = rx_phy[i].payload;
      mrk_all = mrk_all & rx_phy[i][phy_pkg::marker_bit];
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_flit    <= '0;
      marker_err <= 1'b0;
    end else begin
      if (rx_online_delay && mrk_all) begin
        rx_flit <= link_pkg::flit_t'(rx_bits[link_pkg::flit_w-1:0]);
      end else begin
        rx_flit <= '0;
      end
      // One cycle pulse per rejected word
      marker_err <= rx_online_delay & ~mrk_all;
    end
  end

endmodule

`default_nettype wire

// File: logic/link_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module link_master_top (
  input  logic                        clk_wr,
  input  logic                        arst_n,
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic [phy_pkg::delay_w-1:0] delay_x,
  input  logic [phy_pkg::delay_w-1:0] delay_y,
  input  link_pkg::flit_t             dstrm_flit,
  output link_pkg::flit_t             ustrm_flit,
  output phy_pkg::phy_bus_t           tx_phy,
  input  phy_pkg::phy_bus_t           rx_phy,
  output link_pkg::dbg_t              debug_status
);

  ////////////////////////////////////////////////////////////////////
  // Interconnect

  link_pkg::flit_t tx_flit;
  link_pkg::flit_t rx_flit;
  logic            tx_online_delay;
  logic            rx_online_delay;
  logic            tx_mrk;
  logic            tx_stb;
  logic            marker_err;

  ////////////////////////////////////////////////////////////////////
  // Auto sync

  link_auto_sync link_auto_sync_i (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x         (delay_x),
    .delay_y         (delay_y),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_mrk          (tx_mrk),
    .tx_stb          (tx_stb)
  );

  ////////////////////////////////////////////////////////////////////
  // User interface

  link_user_if link_user_if_i (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .dstrm_flit      (dstrm_flit),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .ustrm_flit      (ustrm_flit),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .marker_err      (marker_err),
    .debug_status    (debug_status)
  );

  ////////////////////////////////////////////////////////////////////
  // PHY side

  link_lane_concat link_lane_concat_i (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_mrk          (tx_mrk),
    .tx_stb          (tx_stb),
    .marker_err      (marker_err)
  );

endmodule

`default_nettype wire

// File: logic/link_pkg.sv
`default_nettype none

package link_pkg;

  ////////////////////////////////////////////////////////////////////
  // Flit fields

  localparam int state_w  = 4;
  localparam int protid_w = 2;
  localparam int data_w   = 64;
  localparam int crc_w    = 8;

  // Field order matches the upstream and downstream channels
  typedef struct packed {
    logic [state_w-1:0]  state;
    logic [protid_w-1:0] protid;
    logic [data_w-1:0]   data;
    logic                dvalid;
    logic [crc_w-1:0]    crc;
    logic                crc_valid;
    logic                valid;
  } flit_t;

  localparam int flit_w = $bits(flit_t);

  ////////////////////////////////////////////////////////////////////
  // Debug status

  localparam int cnt_w     = 12;
  localparam int err_cnt_w = 6;

  // Status word, 32 bits wide
  typedef struct packed {
    logic                 tx_online_delay;
    logic                 rx_online_delay;
    logic [err_cnt_w-1:0] marker_err_cnt;
    logic [cnt_w-1:0]     tx_flit_cnt;
    logic [cnt_w-1:0]     rx_flit_cnt;
  } dbg_t;

endpackage

`default_nettype wire

// File: logic/link_user_if.sv
`timescale 1ns/1ps
`default_nettype none

module link_user_if (
  input  logic            clk_wr,
  input  logic            arst_n,
  input  link_pkg::flit_t dstrm_flit,
  output link_pkg::flit_t tx_flit,
  input  link_pkg::flit_t rx_flit,
  output link_pkg::flit_t ustrm_flit,
  input  logic            tx_online_delay,
  input  logic            rx_online_delay,
  input  logic            marker_err,
  output link_pkg::dbg_t  debug_status
);

  logic [link_pkg::cnt_w-1:0]     tx_cnt;
  logic [link_pkg::cnt_w-1:0]     rx_cnt;
  logic [link_pkg::err_cnt_w-1:0] err_cnt;

  ////////////////////////////////////////////////////////////////////
  // Downstream flit register

  // Held at zero until the transmit side is up
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_flit <= '0;
    end else if (tx_online_delay) begin
      tx_flit <= dstrm_flit;
    end else begin
      tx_flit <= '0;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Upstream flit register

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      ustrm_flit <= '0;
    end else begin
      ustrm_flit <= rx_flit;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Debug counters

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_cnt  <= '0;
      rx_cnt  <= '0;
      err_cnt <= '0;
    end else begin
      if (tx_flit.valid) begin
        tx_cnt <= tx_cnt + 1'b1;
      end
      if (rx_flit.valid) begin
        rx_cnt <= rx_cnt + 1'b1;
      end
      // Saturates at all ones
      if (marker_err && (err_cnt != '1)) begin
        err_cnt <= err_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    debug_status                 = '0;
    debug_status.tx_online_delay = tx_online_delay;
    debug_status.rx_online_delay = rx_online_delay;
    debug_status.marker_err_cnt  = err_cnt;
    debug_status.tx_flit_cnt     = tx_cnt;
    debug_status.rx_flit_cnt     = rx_cnt;
  end

endmodule

`default_nettype wire

// File: logic/phy_pkg.sv
`default_nettype none

package phy_pkg;

  ////////////////////////////////////////////////////////////////////
  // Lane geometry

  localparam int lanes     = 4;
  localparam int lane_w    = 24;
  localparam int payload_w = 22;

  // User bit positions inside one lane word
  localparam int strobe_bit = 23;
  localparam int marker_bit = 22;

  // One lane word, strobe on top
  typedef struct packed {
    logic                 stb;
    logic                 mrk;
    logic [payload_w-1:0] payload;
  } lane_t;

  // Lane 0 in the low bits
  typedef lane_t [lanes-1:0] phy_bus_t;

  ////////////////////////////////////////////////////////////////////
  // Online delay programming

  localparam int delay_w = 16;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the link master testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_link_master -f files.f \
  -o sim_link_master \
  && ./obj_dir/sim_link_master 2>&1 | tee sim.log \
  || { echo "Simulation did not complete"; exit 1; }

grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
